// ==== Makefile ====
# Verilator simulation of the trigger pattern generator
# any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_trigger_pattern
FILE_LIST ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_trigger_pattern.sv ====
`timescale 1ns/1ps

module tb_trigger_pattern;
	import trig_pkg::*;

	logic    clock;
	logic    reset1;
	logic    self_mode;
	logic    trig_in;
	logic    serial_out;
	logic    frame_mark;
	logic    sync;
	token_t  token;

	integer seed = 32'h5303;

	// frame collector and model state
	pattern_word_t captured = '0;
	token_t        exp_idx = '0;
	int            bit_idx = 0;
	int            frame_count = 0;
	int            cycle_count = 0;
	bit            spacing_check = 1'b0;
	bit            have_mark = 1'b0;
	int            last_mark = 0;

	trigger_pattern_top i_dut (
		.clock      (clock),
		.reset1     (reset1),
		.self_mode  (self_mode),
		.trig_in    (trig_in),
		.serial_out (serial_out),
		.frame_mark (frame_mark),
		.sync       (sync),
		.token      (token)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic end_with_failure();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_word(input string name, input pattern_word_t got, input pattern_word_t exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
			end_with_failure();
		end
	endtask

	task automatic check_token(input string name, input token_t got, input token_t exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			end_with_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
			end_with_failure();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			end_with_failure();
		end
	endtask

	function automatic int rand_range(input int lo, input int hi);
		int r;
		r = $random(seed);
		r = r & 32'h7fff_ffff;
		return lo + (r % (hi - lo + 1));
	endfunction

	// inputs change just after the rising edge
	task automatic next_cycle(input bit toggle);
		@(posedge clock);
		#1;
		if (toggle) begin
			trig_in = (rand_range(0, 1) == 1);
		end
	endtask

	task automatic wait_frames(input int count, input int limit, input bit toggle);
		int target;
		int waited;
		target = frame_count + count;
		waited = 0;
		while (frame_count < target) begin
			if (waited >= limit) begin
				$display("no frame arrived within %0d cycles, time %0t", limit, $time);
				end_with_failure();
			end
			next_cycle(toggle);
			waited++;
		end
	endtask

	// quiet means no frame on the line for a while
	task automatic wait_quiet(input int limit);
		int quiet;
		int waited;
		quiet = 0;
		waited = 0;
		while (quiet < 16) begin
			if (waited >= limit) begin
				$display("serial line never went quiet within %0d cycles", limit);
				end_with_failure();
			end
			next_cycle(1'b0);
			if (bit_idx != 0 || frame_mark) begin
				quiet = 0;
			end else begin
				quiet++;
			end
			waited++;
		end
	endtask

	// one trigger edge with room for the frame to finish
	task automatic spaced_edge();
		int start;
		int width;
		start = frame_count;
		width = rand_range(1, 4);
		trig_in = 1'b1;
		repeat (width) next_cycle(1'b0);
		trig_in = 1'b0;
		wait_frames(1, 30, 1'b0);
		repeat (rand_range(12, 20)) next_cycle(1'b0);
		check_count("frames per edge", frame_count - start, 1);
	endtask

	// gathers eight bits from each frame_mark, model follows the table
	always @(negedge clock) begin
		cycle_count = cycle_count + 1;
		if (!reset1) begin
			if (bit_idx == 0) begin
				if (frame_mark) begin
					check_bit("sync", sync, exp_idx == 2'd0);
					check_token("token", token, exp_idx + 2'd1);
					if (spacing_check) begin
						if (have_mark) begin
							check_count("frame_mark spacing", cycle_count - last_mark, self_period);
						end
						last_mark = cycle_count;
						have_mark = 1'b1;
					end
					captured = {captured[word_width-2:0], serial_out};
					bit_idx = 1;
				end else begin
					check_bit("serial_out", serial_out, 1'b0);
				end
			end else begin
				check_bit("frame_mark", frame_mark, 1'b0);
				captured = {captured[word_width-2:0], serial_out};
				bit_idx = bit_idx + 1;
				if (bit_idx == word_width) begin
					check_word("word", captured, pattern_table[exp_idx]);
					exp_idx = exp_idx + 2'd1;
					frame_count = frame_count + 1;
					bit_idx = 0;
				end
			end
		end
	end

	initial begin
		int start;
		int edges;
		reset1 = 1'b1;
		self_mode = 1'b0;
		trig_in = 1'b0;
		repeat (3) @(posedge clock);
		#1;
		reset1 = 1'b0;

		// outputs idle right after reset
		repeat (3) begin
			@(negedge clock);
			check_bit("serial_out", serial_out, 1'b0);
			check_bit("frame_mark", frame_mark, 1'b0);
			check_bit("sync", sync, 1'b0);
			check_token("token", token, 2'd0);
		end

		next_cycle(1'b0);
		repeat (10) spaced_edge();

		// long high level gives a single frame
		next_cycle(1'b0);
		start = frame_count;
		trig_in = 1'b1;
		wait_frames(1, 30, 1'b0);
		repeat (40) next_cycle(1'b0);
		trig_in = 1'b0;
		repeat (12) next_cycle(1'b0);
		check_count("frames for held trigger", frame_count - start, 1);

		// dense random edges, some get dropped
		start = frame_count;
		edges = 0;
		repeat (40) begin
			trig_in = 1'b1;
			edges++;
			repeat (rand_range(1, 3)) next_cycle(1'b0);
			trig_in = 1'b0;
			repeat (rand_range(1, 20)) next_cycle(1'b0);
		end
		wait_quiet(200);
		if (frame_count - start > edges) begin
			$display("%0d frames seen for only %0d trigger edges", frame_count - start, edges);
			end_with_failure();
		end
		if (frame_count == start) begin
			$display("dense triggers produced no frame at all");
			end_with_failure();
		end

		// timer drives the frames now, trig_in is noise
		self_mode = 1'b1;
		wait_frames(1, 2 * self_period + 20, 1'b1);
		have_mark = 1'b0;
		spacing_check = 1'b1;
		repeat (6) wait_frames(1, self_period + 16, 1'b1);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== src.f ====
verilog/trig_pkg.sv
verilog/trigger_sync.sv
verilog/pattern_sequencer.sv
verilog/word_serializer.sv
verilog/trigger_pattern_top.sv
sim/tb_trigger_pattern.sv

// ==== verilog/pattern_sequencer.sv ====
`timescale 1ns/1ps

module pattern_sequencer (
	input  logic                    clock,
	input  logic                    reset1,
	input  logic                    self_mode,
	input  logic                    trig_pulse,
	output trig_pkg::pattern_word_t word,
	output logic                    word_valid,
	input  logic                    word_ready,
	output logic                    sync,
	output trig_pkg::token_t        token
);
	import trig_pkg::*;

	seq_state_t state;
	timer_t     timer;
	logic       self_tick;
	logic       trig_event;
	logic       transfer;
	logic       issue;

	// free running, only reset clears it
	always_ff @(posedge clock) begin
		if (reset1) begin
			timer <= '0;
		end else if (timer == timer_t'(self_period - 1)) begin
			timer <= '0;
		end else begin
			timer <= timer + 1'b1;
		end
	end

	assign self_tick = (timer == timer_t'(self_period - 1));

	// self mode ignores the external line completely
	assign trig_event = self_mode ? self_tick : trig_pulse;

	// events arriving in hold are simply lost
	assign issue = (state == idle) && trig_event;

	assign word_valid = (state == hold);
	assign transfer = word_valid && word_ready;

	always_ff @(posedge clock) begin
		if (reset1) begin
			state <= idle;
			token <= '0;
			sync  <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (trig_event) begin
						state <= hold;
						// sync marks the start of the cycle
						if (token == token_t'(0)) begin
							sync <= 1'b1;
						end else if (token == token_t'(1)) begin
							sync <= 1'b0;
						end
					end
				end
				hold: begin
					if (transfer) begin
						state <= idle;
						// advance only once the word is gone
						if (token == token_t'(pattern_count - 1)) begin
							token <= '0;
						end else begin
							token <= token + 1'b1;
						end
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// pattern is latched when the word is issued
	always_ff @(posedge clock) begin
		if (issue) begin
			word <= pattern_table[token];
		end
	end

	// a presented word waits unchanged for the serializer
	assert property (@(posedge clock) disable iff (reset1)
		word_valid && !word_ready |=> word_valid && $stable(word));

	// valid may only drop after a completed transfer
	assert property (@(posedge clock) disable iff (reset1)
		$fell(word_valid) |-> $past(word_ready));

endmodule

// ==== verilog/trig_pkg.sv ====
package trig_pkg;

	// bits per serial frame
	localparam int word_width = 8;

	// words in one pattern cycle
	localparam int pattern_count = 4;

	// clocks between self triggers
	// the board runs 2**25 here, kept short for simulation
	localparam int self_period = 64;

	// derived widths for the counters
	localparam int timer_width = $clog2(self_period);
	localparam int bit_count_width = $clog2(word_width + 1);

	// one frame worth of trigger pattern
	typedef logic [word_width-1:0] pattern_word_t;

	// position in the pattern cycle
	typedef logic [1:0] token_t;

	// self trigger timer value
	typedef logic [timer_width-1:0] timer_t;

	// serial bits still to go out in the current frame
	typedef logic [bit_count_width-1:0] bit_count_t;

	// msb of every entry is set, the receiver locks onto it
	localparam pattern_word_t pattern_table [pattern_count] = '{
		8'b1111_1111,
		8'b1111_1110,
		8'b1100_0000,
		8'b1000_0000
	};

	// sequencer states
	typedef enum logic {
		idle,
		hold
	} seq_state_t;

endpackage

// ==== verilog/trigger_pattern_top.sv ====
`timescale 1ns/1ps

module trigger_pattern_top (
	input  logic             clock,
	input  logic             reset1,
	input  logic             self_mode,
	input  logic             trig_in,
	output logic             serial_out,
	output logic             frame_mark,
	output logic             sync,
	output trig_pkg::token_t token
);
	import trig_pkg::*;

	// one cycle pulse per accepted external edge
	logic trig_pulse;

	// word handshake between sequencer and serializer
	pattern_word_t word;
	logic          word_valid;
	logic          word_ready;

	trigger_sync i_trigger_sync (
		.clock      (clock),
		.reset1     (reset1),
		.trig_in    (trig_in),
		.trig_pulse (trig_pulse)
	);

	// picks the trigger source and hands out the pattern cycle
	pattern_sequencer i_pattern_sequencer (
		.clock      (clock),
		.reset1     (reset1),
		.self_mode  (self_mode),
		.trig_pulse (trig_pulse),
		.word       (word),
		.word_valid (word_valid),
		.word_ready (word_ready),
		.sync       (sync),
		.token      (token)
	);

	word_serializer i_word_serializer (
		.clock      (clock),
		.reset1     (reset1),
		.word       (word),
		.word_valid (word_valid),
		.word_ready (word_ready),
		.serial_out (serial_out),
		.frame_mark (frame_mark)
	);

endmodule

// ==== verilog/trigger_sync.sv ====
`timescale 1ns/1ps

module trigger_sync (
	input  logic clock,
	input  logic reset1,
	input  logic trig_in,
	output logic trig_pulse
);

	// history of the external line, newest bit at the bottom
	// bits 0 and 1 are the synchronizer, bit 2 the previous synced level
	logic [2:0] trig_history;

	// synced level was low and is now high
	logic edge_seen;

	always_ff @(posedge clock) begin
		if (reset1) begin
			trig_history <= '0;
		end else begin
			trig_history <= {trig_history[1:0], trig_in};
		end
	end

	assign edge_seen = !trig_history[2] && trig_history[1];

	// registered so the pulse is clean for one full cycle
	always_ff @(posedge clock) begin
		if (reset1) begin
			trig_pulse <= 1'b0;
		end else begin
			trig_pulse <= edge_seen;
		end
	end

	// a held high input must not keep firing
	assert property (@(posedge clock) disable iff (reset1)
		trig_pulse |=> !trig_pulse);

endmodule

// ==== verilog/word_serializer.sv ====
`timescale 1ns/1ps

module word_serializer (
	input  logic                    clock,
	input  logic                    reset1,
	input  trig_pkg::pattern_word_t word,
	input  logic                    word_valid,
	output logic                    word_ready,
	output logic                    serial_out,
	output logic                    frame_mark
);
	import trig_pkg::*;

	pattern_word_t shift_reg;
	bit_count_t    bits_left;
	logic          transfer;

	assign transfer = word_valid && word_ready;

	// ready already in the last bit cycle so frames can follow with no gap
	assign word_ready = (bits_left <= bit_count_t'(1));

	// shift left, zeros fill in behind so the line idles low
	always_ff @(posedge clock) begin
		if (reset1) begin
			shift_reg <= '0;
		end else if (transfer) begin
			shift_reg <= word;
		end else begin
			shift_reg <= {shift_reg[word_width-2:0], 1'b0};
		end
	end

	// counts down one per bit sent
	always_ff @(posedge clock) begin
		if (reset1) begin
			bits_left <= '0;
		end else if (transfer) begin
			bits_left <= bit_count_t'(word_width);
		end else if (bits_left != '0) begin
			bits_left <= bits_left - 1'b1;
		end
	end

	// msb goes out first
	assign serial_out = shift_reg[word_width-1];

	// full count means the first bit is on the line
	assign frame_mark = (bits_left == bit_count_t'(word_width));

	// every pattern starts with a one, so the marked bit must be high
	assert property (@(posedge clock) disable iff (reset1)
		frame_mark |-> serial_out);

endmodule
